/* hdl/cpu_regs_pkg.sv */
/*
 * CPU general-register block, shared definitions
 * register codes, write sizes, index step sizes, the write-back request
 * and the register dump address map
 */
`default_nettype none

package cpu_regs_pkg;

    // bank-relative group codes, resolved against rfp
    localparam logic [3:0] CUR_BANK   = 4'he;
    localparam logic [3:0] PREV_BANK  = 4'hd;

    // source group that always reads as zero
    localparam logic [3:0] ZERO_GROUP = 4'd4;

    // storage sizes in bytes
    localparam int ACC_BYTES = 64;
    localparam int PTR_BYTES = 16;

    // dump map: accumulators, then pointers, then zeros
    localparam logic [7:0] DUMP_PTR_BASE = 8'h40;
    localparam logic [7:0] DUMP_END      = 8'h50;

    // register code as seen by the decoder
    // group bit 3 set selects the pointer registers
    typedef struct packed {
        logic [3:0] group;
        logic [3:0] index;
    } reg_code_t;

    // write-back size
    typedef enum logic [1:0] {
        W_NONE = 2'd0,
        W_BYTE = 2'd1,
        W_WORD = 2'd2,
        W_LONG = 2'd3
    } width_e;

    // pointer step for indexed addressing, code 3 behaves as STEP_1
    typedef enum logic [1:0] {
        STEP_1 = 2'd0,
        STEP_2 = 2'd1,
        STEP_4 = 2'd2
    } step_e;

    // one write-back after the ALU/RAM selection
    typedef struct packed {
        logic [31:0] data;
        width_e      size;
    } wb_req_t;

endpackage

`default_nettype wire

/* hdl/reg_bank_select.sv */
/*
 * Register bank select
 * holds the register file pointer and turns bank-relative register
 * codes into absolute ones for the source and destination ports
 */
`timescale 1ns/1ps
`default_nettype none

module reg_bank_select (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic                    inc_rfp,
    input  logic                    dec_rfp,
    input  logic                    idx_en,
    input  cpu_regs_pkg::reg_code_t idx_code,
    input  cpu_regs_pkg::reg_code_t src,
    input  cpu_regs_pkg::reg_code_t dst,
    output logic [1:0]              rfp,
    output cpu_regs_pkg::reg_code_t src_code,
    output cpu_regs_pkg::reg_code_t dst_code
);
    import cpu_regs_pkg::*;

    reg_code_t src_sel;

    // swap a bank-relative group for the absolute bank number
    function automatic reg_code_t resolve(
        input reg_code_t  code,
        input logic [1:0] bank
    );
        reg_code_t res;
        res = code;
        if (code.group == CUR_BANK) begin
            res.group = {2'b00, bank};
        end else if (code.group == PREV_BANK) begin
            res.group = {2'b00, bank - 2'd1};
        end
        return res;
    endfunction

    // bank pointer, wraps 3 -> 0 and 0 -> 3
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp <= 2'd0;
        end else if (cen) begin
            if (dec_rfp) begin
                // dec wins when both strobes are set
                rfp <= rfp - 2'd1;
            end else if (inc_rfp) begin
                rfp <= rfp + 2'd1;
            end
        end
    end

    // indexed addressing takes over the source port
    always_comb begin
        src_sel  = idx_en ? idx_code : src;
        src_code = resolve(src_sel, rfp);
        dst_code = resolve(dst, rfp);
    end

endmodule

`default_nettype wire

/* hdl/idx_step_unit.sv */
/*
 * Index step unit
 * decodes the pointer step and builds the pre-decremented destination
 * value and the post-increment / pre-decrement pointer update
 */
`timescale 1ns/1ps
`default_nettype none

module idx_step_unit (
    input  cpu_regs_pkg::step_e step,
    input  logic                reg_inc,
    input  logic                reg_dec,
    input  logic [31:0]         dst_raw,
    output logic [31:0]         dst_out,
    output logic [31:0]         ptr_wdata,
    output logic                ptr_we
);
    import cpu_regs_pkg::*;

    logic [31:0] step_val;

    // step size in bytes
    always_comb begin
        case (step)
            STEP_1:  step_val = 32'd1;
            STEP_2:  step_val = 32'd2;
            STEP_4:  step_val = 32'd4;
            // unused code 3
            default: step_val = 32'd1;
        endcase
    end

    // pre-decrement shows up on the destination port right away
    assign dst_out = reg_dec ? dst_raw - step_val : dst_raw;

    // new pointer value, pre-decrement has priority
    assign ptr_wdata = reg_dec ? dst_out : dst_raw + step_val;

    assign ptr_we = reg_inc | reg_dec;

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
/*
 * Register file storage
 * four banks of byte accumulators plus the shared pointer registers,
 * two combinational 32-bit read ports, byte/word/long write-back,
 * pointer update and a registered byte-wide dump port
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  cpu_regs_pkg::reg_code_t src_code,
    input  cpu_regs_pkg::reg_code_t dst_code,
    output logic [31:0]             src_out,
    output logic [31:0]             dst_raw,
    input  cpu_regs_pkg::wb_req_t   wb,
    input  logic [31:0]             ptr_wdata,
    input  logic                    ptr_we,
    input  logic [7:0]              dmp_addr,
    output logic [7:0]              dmp_data
);
    import cpu_regs_pkg::*;

    logic [7:0] accs [ACC_BYTES];
    logic [7:0] ptrs [PTR_BYTES];

    // write lane addresses within the group and lane enables
    logic [3:0] wr_addr [4];
    logic [3:0] wr_en;

    // one byte of a group, accumulators are banked by group[1:0]
    function automatic logic [7:0] byte_at(
        input reg_code_t  code,
        input logic [3:0] addr
    );
        logic [7:0] value;
        if (code.group[3]) begin
            value = ptrs[addr];
        end else begin
            value = accs[{code.group[1:0], addr}];
        end
        return value;
    endfunction

    // little-endian long, low bytes follow the code, upper half aligned
    function automatic logic [31:0] read_long(input reg_code_t code);
        logic [31:0] value;
        value = {byte_at(code, {code.index[3:2], 2'b11}),
                 byte_at(code, {code.index[3:2], 2'b10}),
                 byte_at(code, {code.index[3:1], 1'b1}),
                 byte_at(code, code.index)};
        return value;
    endfunction

    always_comb begin
        src_out = (src_code.group == ZERO_GROUP) ? 32'd0 : read_long(src_code);
        dst_raw = read_long(dst_code);
    end

    // lane placement, long writes are aligned to four bytes
    always_comb begin
        if (wb.size == W_LONG) begin
            wr_addr[0] = {dst_code.index[3:2], 2'b00};
            wr_addr[1] = {dst_code.index[3:2], 2'b01};
        end else begin
            wr_addr[0] = dst_code.index;
            wr_addr[1] = {dst_code.index[3:1], 1'b1};
        end
        wr_addr[2] = {dst_code.index[3:2], 2'b10};
        wr_addr[3] = {dst_code.index[3:2], 2'b11};

        case (wb.size)
            W_NONE: wr_en = 4'b0000;
            W_BYTE: wr_en = 4'b0001;
            W_WORD: wr_en = 4'b0011;
            W_LONG: wr_en = 4'b1111;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ACC_BYTES; i++) begin
                accs[i] <= 8'd0;
            end
            for (int i = 0; i < PTR_BYTES; i++) begin
                ptrs[i] <= 8'd0;
            end
        end else if (cen) begin
            // write-back at the destination code
            for (int k = 0; k < 4; k++) begin
                if (wr_en[k]) begin
                    if (dst_code.group[3]) begin
                        ptrs[wr_addr[k]] <= wb.data[8*k +: 8];
                    end else begin
                        accs[{dst_code.group[1:0], wr_addr[k]}] <= wb.data[8*k +: 8];
                    end
                end
            end
            // pointer update comes last so it overrides overlapping bytes
            if (ptr_we) begin
                for (int k = 0; k < 4; k++) begin
                    ptrs[{src_code.index[3:2], 2'(k)}] <= ptr_wdata[8*k +: 8];
                end
            end
        end
    end

    // dump byte, one cycle behind the address
    always_ff @(posedge clk) begin
        if (dmp_addr < DUMP_PTR_BASE) begin
            dmp_data <= accs[dmp_addr[5:0]];
        end else if (dmp_addr < DUMP_END) begin
            dmp_data <= ptrs[dmp_addr[3:0]];
        end else begin
            dmp_data <= 8'd0;
        end
    end

endmodule

`default_nettype wire

/* hdl/reg_dump_apb.sv */
/*
 * APB register dump slave
 * read-only window onto the register file dump port, one wait state
 * covers the registered dump byte; writes finish with pslverr
 */
`timescale 1ns/1ps
`default_nettype none

module reg_dump_apb (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [7:0]  dmp_addr,
    input  logic [7:0]  dmp_data
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        WAIT = 2'd1,
        DONE = 2'd2
    } state_e;

    state_e state;
    logic   err_q;

    // master holds paddr until pready
    assign dmp_addr = paddr;

    assign pready  = (state == DONE);
    assign pslverr = pready & err_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            err_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // start on the setup cycle
                    if (psel && !penable) begin
                        err_q <= pwrite;
                        state <= pwrite ? DONE : WAIT;
                    end
                end
                WAIT:    state <= DONE;
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // dump byte is valid during the first access cycle
    always_ff @(posedge clk) begin
        if (state == WAIT) begin
            prdata <= {24'd0, dmp_data};
        end
    end

endmodule

`default_nettype wire

/* hdl/cpu_regs_top.sv */
/*
 * CPU general-register block
 * bank select, register storage, index stepping and the APB dump slave
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_regs_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen,
    input  logic                    inc_rfp,
    input  logic                    dec_rfp,
    input  logic                    idx_en,
    input  cpu_regs_pkg::reg_code_t idx_code,
    input  cpu_regs_pkg::reg_code_t src,
    input  cpu_regs_pkg::reg_code_t dst,
    input  cpu_regs_pkg::step_e     step,
    input  logic                    reg_inc,
    input  logic                    reg_dec,
    input  logic [31:0]             alu_dout,
    input  logic [31:0]             ram_dout,
    input  logic                    data_sel,
    input  cpu_regs_pkg::width_e    alu_we,
    input  cpu_regs_pkg::width_e    ram_we,
    output logic [31:0]             src_out,
    output logic [31:0]             dst_out,
    output logic [1:0]              rfp,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [7:0]              paddr,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr
);
    import cpu_regs_pkg::*;

    reg_code_t   src_code;
    reg_code_t   dst_code;
    logic [31:0] dst_raw;
    logic [31:0] ptr_wdata;
    logic        ptr_we;
    wb_req_t     wb;
    logic [7:0]  dmp_addr;
    logic [7:0]  dmp_data;

    // memory or ALU result
    assign wb.data = data_sel ? ram_dout : alu_dout;
    assign wb.size = data_sel ? ram_we : alu_we;

    reg_bank_select u_bank (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .inc_rfp  (inc_rfp),
        .dec_rfp  (dec_rfp),
        .idx_en   (idx_en),
        .idx_code (idx_code),
        .src      (src),
        .dst      (dst),
        .rfp      (rfp),
        .src_code (src_code),
        .dst_code (dst_code)
    );

    idx_step_unit u_step (
        .step      (step),
        .reg_inc   (reg_inc),
        .reg_dec   (reg_dec),
        .dst_raw   (dst_raw),
        .dst_out   (dst_out),
        .ptr_wdata (ptr_wdata),
        .ptr_we    (ptr_we)
    );

    reg_file u_file (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .src_code  (src_code),
        .dst_code  (dst_code),
        .src_out   (src_out),
        .dst_raw   (dst_raw),
        .wb        (wb),
        .ptr_wdata (ptr_wdata),
        .ptr_we    (ptr_we),
        .dmp_addr  (dmp_addr),
        .dmp_data  (dmp_data)
    );

    reg_dump_apb u_dump (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .dmp_addr (dmp_addr),
        .dmp_data (dmp_data)
    );

endmodule

`default_nettype wire

/* dv/cpu_regs_checker.sv */
/*
 * Register block checker
 * keeps its own model of the registers and the bank pointer, compares
 * the read ports, rfp and APB dump reads against it and counts errors
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_regs_checker (
    input logic                    clk,
    input logic                    rst,
    input logic                    cen,
    input logic                    inc_rfp,
    input logic                    dec_rfp,
    input logic                    idx_en,
    input cpu_regs_pkg::reg_code_t idx_code,
    input cpu_regs_pkg::reg_code_t src,
    input cpu_regs_pkg::reg_code_t dst,
    input cpu_regs_pkg::step_e     step,
    input logic                    reg_inc,
    input logic                    reg_dec,
    input logic [31:0]             alu_dout,
    input logic [31:0]             ram_dout,
    input logic                    data_sel,
    input cpu_regs_pkg::width_e    alu_we,
    input cpu_regs_pkg::width_e    ram_we,
    input logic [31:0]             src_out,
    input logic [31:0]             dst_out,
    input logic [1:0]              rfp,
    input logic                    psel,
    input logic                    penable,
    input logic                    pwrite,
    input logic [7:0]              paddr,
    input logic [31:0]             prdata,
    input logic                    pready,
    input logic                    pslverr
);
    import cpu_regs_pkg::*;

    logic [7:0] acc_m [ACC_BYTES];
    logic [7:0] ptr_m [PTR_BYTES];
    logic [1:0] rfp_m;
    int         errors = 0;
    int         checks = 0;

    // bank-relative groups follow the modeled pointer
    function automatic logic [3:0] resolve_group(input logic [3:0] g);
        if (g == CUR_BANK) begin
            return {2'b00, rfp_m};
        end
        if (g == PREV_BANK) begin
            return {2'b00, rfp_m - 2'd1};
        end
        return g;
    endfunction

    function automatic logic [7:0] model_byte(input logic [3:0] g, input logic [3:0] a);
        return g[3] ? ptr_m[a] : acc_m[{g[1:0], a}];
    endfunction

    // low byte at the code, next at its odd partner, upper half from the aligned long
    function automatic logic [31:0] model_long(input reg_code_t c);
        logic [3:0] g;
        logic [3:0] base;
        g    = resolve_group(c.group);
        base = c.index & 4'hc;
        return {model_byte(g, base | 4'd3), model_byte(g, base | 4'd2),
                model_byte(g, c.index | 4'd1), model_byte(g, c.index)};
    endfunction

    function automatic logic [31:0] step_bytes(input step_e s);
        case (s)
            STEP_2:  return 32'd2;
            STEP_4:  return 32'd4;
            default: return 32'd1;
        endcase
    endfunction

    function automatic logic [7:0] dump_byte(input logic [7:0] a);
        if (a < DUMP_PTR_BASE) begin
            return acc_m[a[5:0]];
        end
        if (a < DUMP_END) begin
            return ptr_m[a[3:0]];
        end
        return 8'd0;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // model state moves on the same edges as the DUT
    always @(posedge clk or posedge rst) begin : model_update
        reg_code_t   s;
        logic [3:0]  dg;
        logic [3:0]  lane;
        logic [31:0] wdata;
        width_e      wsize;
        logic [31:0] new_ptr;
        int          nbytes;
        if (rst) begin
            for (int i = 0; i < ACC_BYTES; i++) begin
                acc_m[i] = 8'd0;
            end
            for (int i = 0; i < PTR_BYTES; i++) begin
                ptr_m[i] = 8'd0;
            end
            rfp_m = 2'd0;
        end else if (cen) begin
            s       = idx_en ? idx_code : src;
            dg      = resolve_group(dst.group);
            wdata   = data_sel ? ram_dout : alu_dout;
            wsize   = data_sel ? ram_we : alu_we;
            new_ptr = reg_dec ? model_long(dst) - step_bytes(step)
                              : model_long(dst) + step_bytes(step);
            case (wsize)
                W_BYTE:  nbytes = 1;
                W_WORD:  nbytes = 2;
                W_LONG:  nbytes = 4;
                default: nbytes = 0;
            endcase
            for (int k = 0; k < nbytes; k++) begin
                lane = (wsize == W_LONG) ? {dst.index[3:2], 2'(k)} : (dst.index | 4'(k));
                if (dg[3]) begin
                    ptr_m[lane] = wdata[8*k +: 8];
                end else begin
                    acc_m[{dg[1:0], lane}] = wdata[8*k +: 8];
                end
            end
            // pointer step lands after the write-back
            if (reg_inc || reg_dec) begin
                for (int k = 0; k < 4; k++) begin
                    ptr_m[{s.index[3:2], 2'(k)}] = new_ptr[8*k +: 8];
                end
            end
            if (dec_rfp) begin
                rfp_m = rfp_m - 2'd1;
            end else if (inc_rfp) begin
                rfp_m = rfp_m + 2'd1;
            end
        end
    end

    // inputs settle shortly after the rising edge, compare in mid cycle
    always @(negedge clk) begin : compare
        reg_code_t   s;
        logic [31:0] exp_src;
        logic [31:0] exp_dst;
        if (!rst) begin
            s       = idx_en ? idx_code : src;
            exp_src = (resolve_group(s.group) == ZERO_GROUP) ? 32'd0 : model_long(s);
            exp_dst = reg_dec ? model_long(dst) - step_bytes(step) : model_long(dst);
            compare_value("src_out", exp_src, src_out);
            compare_value("dst_out", exp_dst, dst_out);
            compare_value("rfp", 32'(rfp_m), 32'(rfp));
            if (psel && penable && pready) begin
                compare_value("pslverr", 32'(pwrite), 32'(pslverr));
                if (!pwrite) begin
                    compare_value("prdata", {24'd0, dump_byte(paddr)}, prdata);
                end
            end else if (pready || pslverr) begin
                errors++;
                $display("At %0t pready or pslverr is high outside an APB access", $time);
            end
        end
    end

endmodule

`default_nettype wire

/* dv/cpu_regs_tb.sv */
/*
 * Testbench for the CPU general-register block
 * walks a stimulus table through the DUT, with APB dump accesses
 * on the rows that ask for one
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_regs_tb;
    import cpu_regs_pkg::*;

    localparam int         CLK_PERIOD   = 40;
    localparam int         RESET_CYCLES = 16;
    localparam int         DRIVE_DELAY  = 2;
    localparam int         APB_LIMIT    = 8;
    localparam logic [1:0] APB_NONE     = 2'd0;
    localparam logic [1:0] APB_RD       = 2'd1;
    localparam logic [1:0] APB_WR       = 2'd2;

    // one table row, control and codes plus an optional APB access
    typedef struct packed {
        logic       cen;
        logic       inc_rfp;
        logic       dec_rfp;
        logic       idx_en;
        reg_code_t  idx_code;
        reg_code_t  src;
        reg_code_t  dst;
        step_e      step;
        logic       reg_inc;
        logic       reg_dec;
        logic       data_sel;
        width_e     alu_we;
        width_e     ram_we;
        logic [1:0] apb;
        logic [7:0] paddr;
    } row_t;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        inc_rfp;
    logic        dec_rfp;
    logic        idx_en;
    reg_code_t   idx_code;
    reg_code_t   src;
    reg_code_t   dst;
    step_e       step;
    logic        reg_inc;
    logic        reg_dec;
    logic [31:0] alu_dout;
    logic [31:0] ram_dout;
    logic        data_sel;
    width_e      alu_we;
    width_e      ram_we;
    logic [31:0] src_out;
    logic [31:0] dst_out;
    logic [1:0]  rfp;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    row_t   rows[$];
    integer seed;
    int     hs_errors   = 0;
    logic   table_ready = 1'b0;

    cpu_regs_top u_dut (.*);

    cpu_regs_checker u_chk (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic reg_code_t code(input logic [3:0] g, input logic [3:0] i);
        return '{group: g, index: i};
    endfunction

    // plain cycle, nothing written
    function automatic row_t read_row(input reg_code_t s, input reg_code_t d);
        row_t r;
        r     = '0;
        r.cen = 1'b1;
        r.src = s;
        r.dst = d;
        return r;
    endfunction

    // the source not selected gets a different size
    function automatic row_t write_row(input reg_code_t s, input reg_code_t d,
                                       input logic sel, input width_e w);
        row_t r;
        r          = read_row(s, d);
        r.data_sel = sel;
        r.alu_we   = sel ? width_e'(~w) : w;
        r.ram_we   = sel ? w : width_e'(~w);
        return r;
    endfunction

    function automatic row_t bank_row(input logic inc, input logic dec);
        row_t r;
        r         = read_row(code(CUR_BANK, 4'd0), code(PREV_BANK, 4'd4));
        r.inc_rfp = inc;
        r.dec_rfp = dec;
        return r;
    endfunction

    function automatic row_t step_row(input reg_code_t p, input step_e s,
                                      input logic inc, input logic dec);
        row_t r;
        r          = read_row(code(4'd0, 4'd0), p);
        r.idx_en   = 1'b1;
        r.idx_code = p;
        r.step     = s;
        r.reg_inc  = inc;
        r.reg_dec  = dec;
        return r;
    endfunction

    function automatic row_t apb_row(input logic [1:0] kind, input logic [7:0] a);
        row_t r;
        r       = read_row(code(4'd8, 4'd0), code(4'd1, 4'd4));
        r.apb   = kind;
        r.paddr = a;
        return r;
    endfunction

    // every write source active, but with the clock enable low
    function automatic row_t frozen_row();
        row_t r;
        r         = step_row(code(4'd8, 4'd0), STEP_4, 1'b1, 1'b0);
        r.dst     = code(4'd0, 4'd0);
        r.alu_we  = W_LONG;
        r.inc_rfp = 1'b1;
        r.cen     = 1'b0;
        return r;
    endfunction

    task automatic build_table();
        logic [31:0] rnd;
        logic [3:0]  g;
        logic [3:0]  ix;
        width_e      w;
        row_t        r;
        step_e       steps [4] = '{STEP_1, STEP_2, STEP_4, step_e'(2'd3)};
        logic [7:0]  addrs [11] = '{8'h00, 8'h07, 8'h13, 8'h2a, 8'h3f, 8'h40,
                                    8'h44, 8'h4b, 8'h4f, 8'h50, 8'hff};
        // random sizes into the banks and the pointers, words kept even
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            g   = rnd[2] ? 4'd8 : {2'b00, rnd[1:0]};
            ix  = rnd[7:4];
            w   = width_e'(rnd[9:8]);
            if (w == W_WORD) begin
                ix[0] = 1'b0;
            end
            rows.push_back(write_row(code(rnd[11] ? 4'd8 : {2'b00, rnd[13:12]}, rnd[17:14]),
                                     code(g, ix), rnd[10], w));
        end
        // bank pointer wraps both ways, dec wins over inc
        repeat (5) rows.push_back(bank_row(1'b1, 1'b0));
        rows.push_back(write_row(code(CUR_BANK, 4'd0), code(CUR_BANK, 4'd0), 1'b0, W_LONG));
        rows.push_back(write_row(code(PREV_BANK, 4'd4), code(PREV_BANK, 4'd4), 1'b1, W_WORD));
        repeat (3) rows.push_back(bank_row(1'b0, 1'b1));
        rows.push_back(bank_row(1'b1, 1'b1));
        rows.push_back(write_row(code(CUR_BANK, 4'd8), code(PREV_BANK, 4'd9), 1'b0, W_BYTE));
        for (int b = 0; b < 4; b++) begin
            rows.push_back(read_row(code(4'(b), 4'd0), code(4'(b), 4'd8)));
        end
        // post-increment on XIX, pre-decrement on XIY
        foreach (steps[i]) begin
            rows.push_back(step_row(code(4'd8, 4'd0), steps[i], 1'b1, 1'b0));
            rows.push_back(step_row(code(4'd8, 4'd4), steps[i], 1'b0, 1'b1));
        end
        // step and long write-back on the same pointer
        r        = step_row(code(4'd8, 4'd8), STEP_4, 1'b1, 1'b0);
        r.alu_we = W_LONG;
        rows.push_back(r);
        rows.push_back(read_row(code(4'd8, 4'd8), code(4'd8, 4'd4)));
        // fresh data behind the zero group alias and the indexed source
        rows.push_back(write_row(code(4'd0, 4'd0), code(4'd0, 4'd0), 1'b1, W_LONG));
        rows.push_back(write_row(code(4'd0, 4'd0), code(4'd1, 4'd8), 1'b0, W_LONG));
        // zero group, and idx_code taking over the source port
        rows.push_back(read_row(code(ZERO_GROUP, 4'd0), code(4'd2, 4'd0)));
        r     = step_row(code(4'd1, 4'd8), STEP_1, 1'b0, 1'b0);
        r.src = code(ZERO_GROUP, 4'd0);
        rows.push_back(r);
        foreach (addrs[i]) begin
            rows.push_back(apb_row(APB_RD, addrs[i]));
        end
        rows.push_back(apb_row(APB_WR, 8'h10));
        rows.push_back(apb_row(APB_RD, 8'h10));
        repeat (2) rows.push_back(frozen_row());
        rows.push_back(read_row(code(4'd0, 4'd0), code(4'd8, 4'd0)));
    endtask

    task automatic drive_row(input row_t r);
        cen      = r.cen;
        inc_rfp  = r.inc_rfp;
        dec_rfp  = r.dec_rfp;
        idx_en   = r.idx_en;
        idx_code = r.idx_code;
        src      = r.src;
        dst      = r.dst;
        step     = r.step;
        reg_inc  = r.reg_inc;
        reg_dec  = r.reg_dec;
        data_sel = r.data_sel;
        alu_we   = r.alu_we;
        ram_we   = r.ram_we;
        alu_dout = $random(seed);
        ram_dout = $random(seed);
    endtask

    // setup cycle starts where the row was applied
    task automatic apb_xfer(input logic wr, input logic [7:0] addr);
        int waits;
        waits   = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge clk);
        while (!pready && waits < APB_LIMIT) begin
            waits++;
            @(negedge clk);
        end
        if (!pready) begin
            hs_errors++;
            $display("APB transfer to address %h never raised pready", addr);
        end else if (waits != (wr ? 0 : 1)) begin
            hs_errors++;
            $display("APB transfer to address %h took %0d wait states", addr, waits);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    initial begin : main
        int total;
        clk     = 1'b0;
        rst     = 1'b1;
        seed    = 32'hdd61bda5;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'd0;
        drive_row('0);
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        foreach (rows[r]) begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_row(rows[r]);
            if (rows[r].apb != APB_NONE) begin
                apb_xfer(rows[r].apb == APB_WR, rows[r].paddr);
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        drive_row(read_row(code(4'd0, 4'd0), code(4'd8, 4'd0)));
        repeat (2) @(posedge clk);
        total = u_chk.errors + hs_errors;
        $display("errors %0d (checker %0d, APB handshake %0d), checks %0d",
                 total, u_chk.errors, hs_errors, u_chk.checks);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // three times the table plus reset, APB rows stretch the run
    initial begin : watchdog
        wait (table_ready);
        #((3 * (rows.size() + RESET_CYCLES)) * CLK_PERIOD + 2000);
        $display("Watchdog expired at %0t, the stimulus table did not finish", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/cpu_regs_pkg.sv
hdl/reg_bank_select.sv
hdl/idx_step_unit.sv
hdl/reg_file.sv
hdl/reg_dump_apb.sv
hdl/cpu_regs_top.sv
dv/cpu_regs_checker.sv
dv/cpu_regs_tb.sv

/* Bender.yml */
package:
  name: cpu_regs

sources:
  - files:
      - hdl/cpu_regs_pkg.sv
      - hdl/reg_bank_select.sv
      - hdl/idx_step_unit.sv
      - hdl/reg_file.sv
      - hdl/reg_dump_apb.sv
      - hdl/cpu_regs_top.sv
  - target: test
    files:
      - dv/cpu_regs_checker.sv
      - dv/cpu_regs_tb.sv
